// ==== dv/core_properties.sv ====
`timescale 1ns/100ps

module core_properties (
    input logic                            clk,
    input logic                            reset,
    input logic                            inst_req,
    input logic                            inst_ack,
    input logic                            wb_valid,
    input logic [mips_pkg::reg_addr_w-1:0] wb_num,
    input logic                            halted
);

    // ack rises one edge after the execute edge, req was high there
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(inst_ack) |-> $past(inst_req))
        else $error("inst_ack rose without inst_req");

    wb_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_valid |=> !wb_valid)
        else $error("wb_valid high for more than one cycle");

    wb_num_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> (wb_num != '0))
        else $error("writeback reported for register zero");

    // no new acknowledge once halted
    quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
        (halted && !inst_ack) |=> !inst_ack)
        else $error("inst_ack rose after the core halted");

endmodule

bind core_top core_properties props0 (
    .clk      (clk),
    .reset    (reset),
    .inst_req (inst_req),
    .inst_ack (inst_ack),
    .wb_valid (wb_valid),
    .wb_num   (wb_num),
    .halted   (halted)
);

// ==== dv/tb_core.sv ====
`timescale 1ns/100ps

module tb_core;

    localparam int n_load  = 16;
    localparam int n_rtype = 400;
    localparam int n_itype = 200;
    localparam int n_misc  = 6;
    localparam int timeout_cycles = (n_load + n_rtype + n_itype + n_misc) * 20 + 10;

    logic        clk;
    logic        reset;
    logic        inst_req;
    logic [31:0] inst_data;
    logic        inst_ack;
    logic        wb_valid;
    logic [4:0]  wb_num;
    logic [31:0] wb_data;
    logic        halted;

    logic [31:0] lfsr_state;
    logic [31:0] ref_regs [32];
    logic [4:0]  exp_num_q [$];
    logic [31:0] exp_data_q [$];
    logic [4:0]  exp_n;
    logic [31:0] exp_d;
    logic [5:0]  r_funcs [11];
    logic [5:0]  i_ops [7];
    logic [31:0] consts [8];
    int          wb_count = 0;
    int          mismatch_errors = 0;
    int          other_errors = 0;

    core_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .inst_req  (inst_req),
        .inst_data (inst_data),
        .inst_ack  (inst_ack),
        .wb_valid  (wb_valid),
        .wb_num    (wb_num),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] v;
        v = rand_bits(5);
        return v[4:0];
    endfunction

    function automatic logic [15:0] rand_imm();
        logic [31:0] v;
        v = rand_bits(16);
        return v[15:0];
    endfunction

    function automatic logic [31:0] r_inst(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
        return {mips_pkg::op_rtype, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_inst(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // expected write target and value from the architectural rules
    function automatic void ref_exec(input logic [31:0] word, output logic writes,
                                     output logic [4:0] num, output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        a = ref_regs[word[25:21]];
        b = ref_regs[word[20:16]];
        simm = {{16{word[15]}}, word[15:0]};
        zimm = {16'h0000, word[15:0]};
        writes = 1'b1;
        num = word[20:16];
        value = '0;
        if (word[31:26] == mips_pkg::op_rtype) begin
            num = word[15:11];
            case (word[5:0])
                mips_pkg::fn_addu: value = a + b;
                mips_pkg::fn_subu: value = a - b;
                mips_pkg::fn_and:  value = a & b;
                mips_pkg::fn_or:   value = a | b;
                mips_pkg::fn_xor:  value = a ^ b;
                mips_pkg::fn_nor:  value = ~(a | b);
                mips_pkg::fn_slt:  value = {31'd0, $signed(a) < $signed(b)};
                mips_pkg::fn_sltu: value = {31'd0, a < b};
                mips_pkg::fn_sll:  value = b << word[10:6];
                mips_pkg::fn_srl:  value = b >> word[10:6];
                // logical shift with the vacated top bits filled from the sign
                mips_pkg::fn_sra:  value = (b >> word[10:6]) |
                                           (b[31] ? ~(32'hffffffff >> word[10:6]) : 32'h0);
                default:           writes = 1'b0;
            endcase
        end else begin
            case (word[31:26])
                mips_pkg::op_addiu: value = a + simm;
                mips_pkg::op_slti:  value = {31'd0, $signed(a) < $signed(simm)};
                mips_pkg::op_sltiu: value = {31'd0, a < simm};
                mips_pkg::op_andi:  value = a & zimm;
                mips_pkg::op_ori:   value = a | zimm;
                mips_pkg::op_xori:  value = a ^ zimm;
                mips_pkg::op_lui:   value = {word[15:0], 16'h0000};
                default:            writes = 1'b0;
            endcase
        end
        // r0 is never reported
        if (num == '0) begin
            writes = 1'b0;
        end
    endfunction

    // four-phase send starting on a falling edge
    task automatic send_inst(input logic [31:0] word, input int hold, input int limit,
                             output logic acked);
        int waited;
        acked = 1'b0;
        waited = 0;
        inst_data = word;
        inst_req = 1'b1;
        while (!acked && waited < limit) begin
            @(negedge clk);
            waited++;
            if (inst_ack) begin
                acked = 1'b1;
            end
        end
        if (acked) begin
            repeat (hold) begin
                @(negedge clk);
                if (!inst_ack) begin
                    other_errors++;
                    $display("%0t: inst_ack fell while inst_req was still high", $time);
                end
            end
        end
        inst_req = 1'b0;
        if (acked) begin
            @(negedge clk);
            if (inst_ack) begin
                other_errors++;
                $display("%0t: inst_ack still high one cycle after inst_req fell", $time);
            end
            while (inst_ack) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic issue_inst(input logic [31:0] word);
        logic        writes;
        logic [4:0]  num;
        logic [31:0] value;
        logic        acked;
        int          wb_before;
        int          hold;
        ref_exec(word, writes, num, value);
        if (writes) begin
            exp_num_q.push_back(num);
            exp_data_q.push_back(value);
            ref_regs[num] = value;
        end
        hold = rand_bits(2);
        wb_before = wb_count;
        send_inst(word, hold, 20, acked);
        if (!acked) begin
            other_errors++;
            $display("%0t: instruction %h was not acknowledged within 20 cycles", $time, word);
        end
        if ((wb_count - wb_before) != (writes ? 1 : 0)) begin
            other_errors++;
            $display("%0t: instruction %h gave %0d writebacks, expected %0d", $time, word,
                     wb_count - wb_before, writes ? 1 : 0);
        end
    endtask

    // compare each writeback against the queued expectation
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            wb_count++;
            if (exp_num_q.size() == 0) begin
                other_errors++;
                $display("%0t: writeback to register %0d that no instruction expected",
                         $time, wb_num);
            end else begin
                exp_n = exp_num_q.pop_front();
                exp_d = exp_data_q.pop_front();
                if (wb_num !== exp_n) begin
                    mismatch_errors++;
                    $display("MISMATCH at %0t: wb_num got %0d expected %0d", $time, wb_num, exp_n);
                end
                if (wb_data !== exp_d) begin
                    mismatch_errors++;
                    $display("MISMATCH at %0t: wb_data got %h expected %h", $time, wb_data, exp_d);
                end
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the core or the handshake hung",
                 timeout_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic acked;
        lfsr_state = 32'hecae;
        reset = 1'b1;
        inst_req = 1'b0;
        inst_data = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        r_funcs = '{mips_pkg::fn_addu, mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
                    mips_pkg::fn_xor, mips_pkg::fn_nor, mips_pkg::fn_slt, mips_pkg::fn_sltu,
                    mips_pkg::fn_sll, mips_pkg::fn_srl, mips_pkg::fn_sra};
        i_ops = '{mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu, mips_pkg::op_andi,
                  mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui};
        consts = '{32'h12345678, 32'h80000000, 32'hffffffff, 32'h7fffffff,
                   32'h0000ffff, 32'hfffe0001, 32'h00008000, 32'hdeadbeef};
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // constants into r1..r8
        for (int i = 0; i < 8; i++) begin
            issue_inst(i_inst(mips_pkg::op_lui, 5'd0, 5'(i + 1), consts[i][31:16]));
            issue_inst(i_inst(mips_pkg::op_ori, 5'(i + 1), 5'(i + 1), consts[i][15:0]));
        end

        for (int i = 0; i < n_rtype; i++) begin
            issue_inst(r_inst(r_funcs[rand_bits(4) % 32'd11], rand_reg(), rand_reg(),
                              rand_reg(), rand_reg()));
        end

        for (int i = 0; i < n_itype; i++) begin
            issue_inst(i_inst(i_ops[rand_bits(3) % 32'd7], rand_reg(), rand_reg(), rand_imm()));
        end

        // writes to r0 are dropped
        issue_inst(r_inst(mips_pkg::fn_addu, 5'd1, 5'd2, 5'd0, 5'd0));
        issue_inst(i_inst(mips_pkg::op_ori, 5'd0, 5'd0, 16'h1234));
        issue_inst(r_inst(mips_pkg::fn_addu, 5'd0, 5'd0, 5'd9, 5'd0));
        issue_inst(r_inst(mips_pkg::fn_addu, 5'd0, 5'd3, 5'd10, 5'd0));

        issue_inst(r_inst(mips_pkg::fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
        if (halted !== 1'b1) begin
            other_errors++;
            $display("%0t: halted did not rise after syscall", $time);
        end
        send_inst(i_inst(mips_pkg::op_addiu, 5'd0, 5'd11, 16'h0001), 0, 20, acked);
        if (acked) begin
            other_errors++;
            $display("%0t: request after halt was acknowledged", $time);
        end else begin
            $display("%0t: request after halt not acknowledged, as expected", $time);
        end

        repeat (2) @(negedge clk);
        if (exp_num_q.size() != 0) begin
            other_errors++;
            $display("%0t: %0d expected writebacks never arrived", $time, exp_num_q.size());
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  logic [mips_pkg::alu_op_w-1:0]   alu_op,
    input  logic [mips_pkg::data_w-1:0]     a,
    input  logic [mips_pkg::data_w-1:0]     b,
    input  logic [mips_pkg::reg_addr_w-1:0] shamt,
    output logic [mips_pkg::data_w-1:0]     result
);

    always_comb begin
        case (alu_op)
            mips_pkg::alu_add: begin
                result = a + b;
            end
            mips_pkg::alu_sub: begin
                result = a - b;
            end
            mips_pkg::alu_and: begin
                result = a & b;
            end
            mips_pkg::alu_or: begin
                result = a | b;
            end
            mips_pkg::alu_xor: begin
                result = a ^ b;
            end
            mips_pkg::alu_nor: begin
                result = ~(a | b);
            end
            mips_pkg::alu_slt: begin
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            mips_pkg::alu_sltu: begin
                result = (a < b) ? 32'd1 : 32'd0;
            end
            // shifts act on the rt operand
            mips_pkg::alu_sll: begin
                result = b << shamt;
            end
            mips_pkg::alu_srl: begin
                result = b >> shamt;
            end
            mips_pkg::alu_sra: begin
                result = $unsigned($signed(b) >>> shamt);
            end
            mips_pkg::alu_lui: begin
                result = {b[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== hw/controller.sv ====
`timescale 1ns/100ps

module controller (
    input  logic [mips_pkg::op_w-1:0]     opcode,
    input  logic [mips_pkg::op_w-1:0]     func,
    output logic [mips_pkg::alu_op_w-1:0] alu_op,
    output logic                          alu_src,
    output logic [1:0]                    destination_register,
    output logic                          register_write,
    output logic                          is_unsigned,
    output logic                          halt
);

    always_comb begin
        alu_op               = mips_pkg::alu_add;
        alu_src              = 1'b0;
        destination_register = mips_pkg::dst_rt;
        register_write       = 1'b0;
        is_unsigned          = 1'b0;
        halt                 = 1'b0;

        case (opcode)
            mips_pkg::op_rtype: begin
                destination_register = mips_pkg::dst_rd;
                register_write       = 1'b1;
                case (func)
                    mips_pkg::fn_sll:  alu_op = mips_pkg::alu_sll;
                    mips_pkg::fn_srl:  alu_op = mips_pkg::alu_srl;
                    mips_pkg::fn_sra:  alu_op = mips_pkg::alu_sra;
                    mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
                    mips_pkg::fn_nor:  alu_op = mips_pkg::alu_nor;
                    mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_sltu: alu_op = mips_pkg::alu_sltu;
                    mips_pkg::fn_syscall: begin
                        register_write = 1'b0;
                        halt           = 1'b1;
                    end
                    default: register_write = 1'b0;
                endcase
            end
            mips_pkg::op_addiu,
            mips_pkg::op_slti,
            mips_pkg::op_sltiu,
            mips_pkg::op_andi,
            mips_pkg::op_ori,
            mips_pkg::op_xori,
            mips_pkg::op_lui: begin
                alu_src        = 1'b1;
                register_write = 1'b1;
                case (opcode)
                    mips_pkg::op_slti:  alu_op = mips_pkg::alu_slt;
                    mips_pkg::op_sltiu: alu_op = mips_pkg::alu_sltu;
                    mips_pkg::op_andi:  alu_op = mips_pkg::alu_and;
                    mips_pkg::op_ori:   alu_op = mips_pkg::alu_or;
                    mips_pkg::op_xori:  alu_op = mips_pkg::alu_xor;
                    mips_pkg::op_lui:   alu_op = mips_pkg::alu_lui;
                    default:            alu_op = mips_pkg::alu_add;
                endcase
                // logical immediates are zero extended
                is_unsigned = (opcode == mips_pkg::op_andi) ||
                              (opcode == mips_pkg::op_ori)  ||
                              (opcode == mips_pkg::op_xori);
            end
            default: register_write = 1'b0;
        endcase
    end

endmodule

// ==== hw/core_top.sv ====
`timescale 1ns/100ps

module core_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            inst_req,
    input  logic [mips_pkg::data_w-1:0]     inst_data,
    output logic                            inst_ack,
    output logic                            wb_valid,
    output logic [mips_pkg::reg_addr_w-1:0] wb_num,
    output logic [mips_pkg::data_w-1:0]     wb_data,
    output logic                            halted
);

    logic [mips_pkg::data_w-1:0]     inst;
    logic                            wb_we;
    logic [mips_pkg::data_w-1:0]     rs_data;
    logic [mips_pkg::data_w-1:0]     operand_b;
    logic [mips_pkg::reg_addr_w-1:0] shamt;
    logic [mips_pkg::alu_op_w-1:0]   alu_op;
    logic [mips_pkg::reg_addr_w-1:0] write_num;
    logic                            write_en;
    logic                            halt;
    logic [mips_pkg::data_w-1:0]     result;

    inst_port port0 (
        .clk       (clk),
        .reset     (reset),
        .inst_req  (inst_req),
        .inst_data (inst_data),
        .inst_ack  (inst_ack),
        .inst      (inst),
        .wb_we     (wb_we),
        .write_num (write_num),
        .write_en  (write_en),
        .halt      (halt),
        .result    (result),
        .wb_valid  (wb_valid),
        .wb_num    (wb_num),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    // rt_data already carries the immediate when selected
    decode_stage id0 (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .wb_we      (wb_we),
        .wb_result  (result),
        .rs_data    (rs_data),
        .rt_data    (operand_b),
        .imm_extend (),
        .shamt      (shamt),
        .alu_op     (alu_op),
        .alu_src    (),
        .write_num  (write_num),
        .write_en   (write_en),
        .halt       (halt)
    );

    alu alu0 (
        .alu_op (alu_op),
        .a      (rs_data),
        .b      (operand_b),
        .shamt  (shamt),
        .result (result)
    );

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [mips_pkg::data_w-1:0]     inst,
    input  logic                            wb_we,
    input  logic [mips_pkg::data_w-1:0]     wb_result,
    output logic [mips_pkg::data_w-1:0]     rs_data,
    output logic [mips_pkg::data_w-1:0]     rt_data,
    output logic [mips_pkg::data_w-1:0]     imm_extend,
    output logic [mips_pkg::reg_addr_w-1:0] shamt,
    output logic [mips_pkg::alu_op_w-1:0]   alu_op,
    output logic                            alu_src,
    output logic [mips_pkg::reg_addr_w-1:0] write_num,
    output logic                            write_en,
    output logic                            halt
);

    logic [mips_pkg::reg_addr_w-1:0] rs_num;
    logic [mips_pkg::reg_addr_w-1:0] rt_num;
    logic [mips_pkg::reg_addr_w-1:0] rd_num;
    logic [mips_pkg::data_w-1:0]     rt_read;
    logic [1:0]                      destination_register;
    logic                            is_unsigned;

    assign rs_num = inst[25:21];
    assign rt_num = inst[20:16];
    assign rd_num = inst[15:11];
    assign shamt  = inst[10:6];

    regfile regs (
        .clk     (clk),
        .reset   (reset),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rd_num  (write_num),
        .rd_data (wb_result),
        .rd_we   (wb_we & write_en),
        .rs_data (rs_data),
        .rt_data (rt_read)
    );

    controller ctrl (
        .opcode               (inst[31:26]),
        .func                 (inst[5:0]),
        .alu_op               (alu_op),
        .alu_src              (alu_src),
        .destination_register (destination_register),
        .register_write       (write_en),
        .is_unsigned          (is_unsigned),
        .halt                 (halt)
    );

    // immediate extender
    assign imm_extend = is_unsigned ? {16'h0000, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};

    assign write_num = (destination_register == mips_pkg::dst_rd) ? rd_num : rt_num;

    // b operand for the alu takes the immediate for i-type
    assign rt_data = alu_src ? imm_extend : rt_read;

endmodule

// ==== hw/inst_port.sv ====
`timescale 1ns/100ps

module inst_port (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            inst_req,
    input  logic [mips_pkg::data_w-1:0]     inst_data,
    output logic                            inst_ack,
    output logic [mips_pkg::data_w-1:0]     inst,
    output logic                            wb_we,
    input  logic [mips_pkg::reg_addr_w-1:0] write_num,
    input  logic                            write_en,
    input  logic                            halt,
    input  logic [mips_pkg::data_w-1:0]     result,
    output logic                            wb_valid,
    output logic [mips_pkg::reg_addr_w-1:0] wb_num,
    output logic [mips_pkg::data_w-1:0]     wb_data,
    output logic                            halted
);

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_ack
    } state_t;

    state_t state;
    logic   take;

    assign take     = (state == st_idle) && inst_req && !inst_ack && !halted;
    assign inst_ack = (state == st_ack);
    // one write strobe per instruction
    assign wb_we    = (state == st_exec);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            wb_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            wb_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (take) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    state    <= st_ack;
                    // nothing to report for halt or a write to r0
                    wb_valid <= write_en && !halt && (write_num != '0);
                    if (halt) begin
                        halted <= 1'b1;
                    end
                end
                st_ack: begin
                    // hold ack until the requester drops req
                    if (!inst_req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            inst <= inst_data;
        end
        if (state == st_exec) begin
            wb_num  <= write_num;
            wb_data <= result;
        end
    end

endmodule

// ==== hw/mips_pkg.sv ====
package mips_pkg;

    // widths
    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int op_w       = 6;
    localparam int alu_op_w   = 5;

    // primary opcodes in inst[31:26]
    localparam logic [op_w-1:0] op_rtype = 6'h00;
    localparam logic [op_w-1:0] op_addiu = 6'h09;
    localparam logic [op_w-1:0] op_slti  = 6'h0a;
    localparam logic [op_w-1:0] op_sltiu = 6'h0b;
    localparam logic [op_w-1:0] op_andi  = 6'h0c;
    localparam logic [op_w-1:0] op_ori   = 6'h0d;
    localparam logic [op_w-1:0] op_xori  = 6'h0e;
    localparam logic [op_w-1:0] op_lui   = 6'h0f;

    // r-type function field in inst[5:0]
    localparam logic [op_w-1:0] fn_sll     = 6'h00;
    localparam logic [op_w-1:0] fn_srl     = 6'h02;
    localparam logic [op_w-1:0] fn_sra     = 6'h03;
    localparam logic [op_w-1:0] fn_syscall = 6'h0c;
    localparam logic [op_w-1:0] fn_addu    = 6'h21;
    localparam logic [op_w-1:0] fn_subu    = 6'h23;
    localparam logic [op_w-1:0] fn_and     = 6'h24;
    localparam logic [op_w-1:0] fn_or      = 6'h25;
    localparam logic [op_w-1:0] fn_xor     = 6'h26;
    localparam logic [op_w-1:0] fn_nor     = 6'h27;
    localparam logic [op_w-1:0] fn_slt     = 6'h2a;
    localparam logic [op_w-1:0] fn_sltu    = 6'h2b;

    // alu operations
    localparam logic [alu_op_w-1:0] alu_add  = 5'd0;
    localparam logic [alu_op_w-1:0] alu_sub  = 5'd1;
    localparam logic [alu_op_w-1:0] alu_and  = 5'd2;
    localparam logic [alu_op_w-1:0] alu_or   = 5'd3;
    localparam logic [alu_op_w-1:0] alu_xor  = 5'd4;
    localparam logic [alu_op_w-1:0] alu_nor  = 5'd5;
    localparam logic [alu_op_w-1:0] alu_slt  = 5'd6;
    localparam logic [alu_op_w-1:0] alu_sltu = 5'd7;
    localparam logic [alu_op_w-1:0] alu_sll  = 5'd8;
    localparam logic [alu_op_w-1:0] alu_srl  = 5'd9;
    localparam logic [alu_op_w-1:0] alu_sra  = 5'd10;
    localparam logic [alu_op_w-1:0] alu_lui  = 5'd11;

    // write register select
    localparam logic [1:0] dst_rt = 2'b00;
    localparam logic [1:0] dst_rd = 2'b01;

endpackage

// ==== hw/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [mips_pkg::reg_addr_w-1:0] rs_num,
    input  logic [mips_pkg::reg_addr_w-1:0] rt_num,
    input  logic [mips_pkg::reg_addr_w-1:0] rd_num,
    input  logic [mips_pkg::data_w-1:0]     rd_data,
    input  logic                            rd_we,
    output logic [mips_pkg::data_w-1:0]     rs_data,
    output logic [mips_pkg::data_w-1:0]     rt_data
);

    // register zero has no storage
    logic [mips_pkg::data_w-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_num != '0)) begin
            regs[rd_num] <= rd_data;
        end
    end

    always_comb begin
        if (rs_num == '0) begin
            rs_data = '0;
        end else begin
            rs_data = regs[rs_num];
        end
    end

    always_comb begin
        if (rt_num == '0) begin
            rt_data = '0;
        end else begin
            rt_data = regs[rt_num];
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_core -o tb_core_sim &&
./obj_dir/tb_core_sim | tee /dev/stderr | grep -qx "Test OK" &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}

// ==== tb.f ====
hw/mips_pkg.sv
hw/regfile.sv
hw/controller.sv
hw/decode_stage.sv
hw/alu.sv
hw/inst_port.sv
hw/core_top.sv
dv/core_properties.sv
dv/tb_core.sv
